// File: rtl/sm83_bus_pkg.sv
package sm83_bus_pkg;

	// width of one data byte, on the bus and in every register
	localparam int WORD_SIZE = 8;

	// width of a memory address, which is also the width of one register pair
	localparam int ADR_WIDTH = 16;

	// one byte as it moves between memory, the latches and the register file
	typedef logic [WORD_SIZE-1:0] word_t;

	// a bus address, or a full register pair used as one
	typedef logic [ADR_WIDTH-1:0] adr_t;

	// PC after reset, so the first real opcode fetch reads this address
	localparam adr_t RESET_PC = 16'h0000;

endpackage

// File: rtl/sm83_isa_pkg.sv
package sm83_isa_pkg;

	// register pair codes, also the upper two bits of a register field
	localparam logic [1:0] PAIR_BC = 2'd0;
	localparam logic [1:0] PAIR_DE = 2'd1;
	localparam logic [1:0] PAIR_HL = 2'd2;
	localparam logic [1:0] PAIR_AF = 2'd3;

	// field code 6 means memory at HL instead of a register
	localparam logic [2:0] REG_HL_IND = 3'd6;
	// A is field 7, the high byte of AF
	localparam logic [2:0] REG_A = 3'd7;

	// opcode groups taken from the top two bits
	localparam logic [1:0] GRP_MISC = 2'b00;
	localparam logic [1:0] GRP_LD_R_R = 2'b01;

	// the low three bits shared by LD (BC),A, LD (DE),A and their reverse forms
	localparam logic [2:0] COL_LD_IND = 3'd2;

	localparam logic [7:0] OP_NOP = 8'h00;
	localparam logic [7:0] OP_LD_HL_N = 8'h36;

	// the 01dddsss and 00ddd110 load forms
	typedef struct packed {
		logic [1:0] grp;
		logic [2:0] dst;
		logic [2:0] src;
	} ld_view_t;

	// the 00pp d010 forms, dir is 1 for a load into A and 0 for a store from A
	typedef struct packed {
		logic [1:0] grp;
		logic [1:0] pair;
		logic       dir;
		logic [2:0] col;
	} pair_view_t;

	// one opcode byte, read through whichever view the instruction needs
	typedef union packed {
		ld_view_t   ld;
		pair_view_t pr;
	} opcode_u;

endpackage

// File: rtl/sm83_sequencer.sv
`timescale 1ns/1ps

module sm83_sequencer (
	input  logic clk,
	input  logic reset,
	input  logic set_m1,
	output logic m1,
	output logic m2,
	output logic m3,
	output logic t1,
	output logic t2,
	output logic t3,
	output logic t4,
	output logic in_rst
);

	// T-state count, 0 is T1 and 3 is T4
	logic [1:0] t_cnt;
	// one-hot M-cycle, bit 0 is M1
	logic [2:0] m_state;

	assign t1 = (t_cnt == 2'd0);
	assign t2 = (t_cnt == 2'd1);
	assign t3 = (t_cnt == 2'd2);
	assign t4 = (t_cnt == 2'd3);

	assign m1 = m_state[0];
	assign m2 = m_state[1];
	assign m3 = m_state[2];

	always_ff @(posedge clk) begin
		if (reset) begin
			t_cnt   <= 2'd0;
			m_state <= 3'b001;
		end else begin
			// the two-bit count wraps from T4 back to T1 by itself
			t_cnt <= t_cnt + 2'd1;
			// the M-cycle only moves on at the end of T4
			if (t4) begin
				if (set_m1)
					m_state <= 3'b001;
				else
					m_state <= {m_state[1:0], m_state[2]};
			end
		end
	end

	// the first M1 after reset runs a forced nop without a bus read
	always_ff @(posedge clk) begin
		if (reset)
			in_rst <= 1'b1;
		else if (t4 && set_m1)
			in_rst <= 1'b0;
	end

endmodule

// File: rtl/sm83_control.sv
`timescale 1ns/1ps

module sm83_control (
	input  sm83_isa_pkg::opcode_u opcode,
	input  logic                  m1,
	input  logic                  m2,
	input  logic                  m3,
	input  logic                  t1,
	input  logic                  t2,
	input  logic                  t3,
	input  logic                  t4,
	input  logic                  in_rst,
	output logic                  set_m1,
	output logic                  mem_rd,
	output logic                  mem_wr,
	output logic [1:0]            reg_sel,
	output logic                  read_hi,
	output logic                  hi_we,
	output logic                  lo_we,
	output logic                  pc_to_adr,
	output logic                  reg_to_adr,
	output logic                  pc_inc_we,
	output logic                  data_we,
	output logic                  data_from_reg,
	output logic                  ir_we,
	output logic                  ir_zero,
	output logic                  wlatch_we
);

	// true when a register field names the high byte of its pair, A being the odd one
	function automatic logic field_hi(input logic [2:0] field);
		if (field[2:1] == sm83_isa_pkg::PAIR_AF)
			return field[0];
		return !field[0];
	endfunction

	logic       ld_r_r;
	logic       ld_r_hl;
	logic       ld_hl_r;
	logic       ld_r_n;
	logic       ld_hl_n;
	logic       ld_ind;
	logic       ld_a_ind;
	logic       ld_ind_a;
	logic       wb_en;
	logic [2:0] wb_field;
	logic [2:0] st_field;
	logic [1:0] ptr_pair;

	// 76 has both fields at 6 and falls through to the nop branch
	assign ld_r_r  = (opcode.ld.grp == sm83_isa_pkg::GRP_LD_R_R) &&
		(opcode.ld.dst != sm83_isa_pkg::REG_HL_IND) && (opcode.ld.src != sm83_isa_pkg::REG_HL_IND);
	assign ld_r_hl = (opcode.ld.grp == sm83_isa_pkg::GRP_LD_R_R) &&
		(opcode.ld.dst != sm83_isa_pkg::REG_HL_IND) && (opcode.ld.src == sm83_isa_pkg::REG_HL_IND);
	assign ld_hl_r = (opcode.ld.grp == sm83_isa_pkg::GRP_LD_R_R) &&
		(opcode.ld.dst == sm83_isa_pkg::REG_HL_IND) && (opcode.ld.src != sm83_isa_pkg::REG_HL_IND);
	assign ld_r_n  = (opcode.ld.grp == sm83_isa_pkg::GRP_MISC) &&
		(opcode.ld.dst != sm83_isa_pkg::REG_HL_IND) && (opcode.ld.src == sm83_isa_pkg::REG_HL_IND);
	assign ld_hl_n = (opcode == sm83_isa_pkg::OP_LD_HL_N);

	// only the BC and DE pointer forms are kept, the HL ones act as nop
	assign ld_ind   = (opcode.pr.grp == sm83_isa_pkg::GRP_MISC) &&
		(opcode.pr.col == sm83_isa_pkg::COL_LD_IND) &&
		((opcode.pr.pair == sm83_isa_pkg::PAIR_BC) || (opcode.pr.pair == sm83_isa_pkg::PAIR_DE));
	assign ld_a_ind = ld_ind && opcode.pr.dir;
	assign ld_ind_a = ld_ind && !opcode.pr.dir;

	// loads that land in a register finish with a write-back in the next M1
	assign wb_en    = ld_r_r || ld_r_n || ld_r_hl || ld_a_ind;
	assign wb_field = ld_a_ind ? sm83_isa_pkg::REG_A : opcode.ld.dst;
	assign st_field = ld_ind_a ? sm83_isa_pkg::REG_A : opcode.ld.src;
	assign ptr_pair = ld_ind ? opcode.pr.pair : sm83_isa_pkg::PAIR_HL;

	// the IR takes the fetched byte in T4 of M1, zeroed for the reset fetch
	assign ir_we   = m1 && t4;
	assign ir_zero = m1 && t4 && in_rst;

	always_comb begin
		set_m1        = 1'b0;
		mem_rd        = 1'b0;
		mem_wr        = 1'b0;
		reg_sel       = sm83_isa_pkg::PAIR_BC;
		read_hi       = 1'b0;
		hi_we         = 1'b0;
		lo_we         = 1'b0;
		pc_to_adr     = 1'b0;
		reg_to_adr    = 1'b0;
		pc_inc_we     = 1'b0;
		data_we       = 1'b0;
		data_from_reg = 1'b0;
		wlatch_we     = 1'b0;

		// up to T3 of M1 the IR still holds the previous instruction
		if (m1 && t3 && wb_en) begin
			reg_sel = wb_field[2:1];
			hi_we   = field_hi(wb_field);
			lo_we   = !field_hi(wb_field);
		end

		if (ld_r_r) begin
			// source byte goes into the data latch at T1 and is written back at T3
			if (m1 && t1) begin
				reg_sel       = opcode.ld.src[2:1];
				read_hi       = field_hi(opcode.ld.src);
				data_we       = 1'b1;
				data_from_reg = 1'b1;
			end
			set_m1 = m1 && t4;
		end else if (ld_r_n || ld_hl_n) begin
			// immediate byte read in M2 at PC, which then steps past it
			if (m1 && t4)
				pc_to_adr = 1'b1;
			if (m2 && t1) begin
				mem_rd    = 1'b1;
				pc_inc_we = 1'b1;
			end
			if (m2 && t3)
				data_we = 1'b1;
			if (ld_r_n) begin
				set_m1 = m2 && t4;
			end else begin
				// LD (HL),n then stores the immediate at HL during M3
				if (m2 && t4) begin
					reg_sel    = sm83_isa_pkg::PAIR_HL;
					reg_to_adr = 1'b1;
				end
				wlatch_we = m3 && t2;
				mem_wr    = m3 && t3;
				set_m1    = m3 && t4;
			end
		end else if (ld_r_hl || ld_a_ind) begin
			// pointer read in M2, the byte waits in the data latch for write-back
			if (m1 && t4) begin
				reg_sel    = ptr_pair;
				reg_to_adr = 1'b1;
			end
			mem_rd  = m2 && t1;
			data_we = m2 && t3;
			set_m1  = m2 && t4;
		end else if (ld_hl_r || ld_ind_a) begin
			if (m1 && t4) begin
				reg_sel    = ptr_pair;
				reg_to_adr = 1'b1;
			end
			// the register byte reaches the write latch one clock before the strobe
			if (m2 && t2) begin
				reg_sel       = st_field[2:1];
				read_hi       = field_hi(st_field);
				data_from_reg = 1'b1;
				wlatch_we     = 1'b1;
			end
			mem_wr = m2 && t3;
			set_m1 = m2 && t4;
		end else begin
			set_m1 = m1 && t4;
		end

		// next opcode fetch, overlapping the tail of this instruction
		if (set_m1)
			pc_to_adr = 1'b1;
		if (m1 && t1 && !in_rst) begin
			mem_rd    = 1'b1;
			pc_inc_we = 1'b1;
		end
		if (m1 && t3)
			data_we = 1'b1;
	end

endmodule

// File: rtl/sm83_regfile.sv
`timescale 1ns/1ps

module sm83_regfile (
	input  logic                clk,
	input  logic                reset,
	input  logic [1:0]          reg_sel,
	input  logic                read_hi,
	input  logic                hi_we,
	input  logic                lo_we,
	input  sm83_bus_pkg::word_t wdata,
	output sm83_bus_pkg::word_t rdata,
	output sm83_bus_pkg::adr_t  pair_value
);

	// BC, DE, HL and AF, indexed by the pair code
	sm83_bus_pkg::adr_t pairs [4];

	// the whole pair serves as a pointer for the address unit
	assign pair_value = pairs[reg_sel];

	// byte read for stores and register to register moves
	assign rdata = read_hi ?
		pair_value[sm83_bus_pkg::ADR_WIDTH-1:sm83_bus_pkg::WORD_SIZE] :
		pair_value[sm83_bus_pkg::WORD_SIZE-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			foreach (pairs[i])
				pairs[i] <= '0;
		end else begin
			// control raises at most one of the two enables in a clock
			if (hi_we)
				pairs[reg_sel][sm83_bus_pkg::ADR_WIDTH-1:sm83_bus_pkg::WORD_SIZE] <= wdata;
			if (lo_we)
				pairs[reg_sel][sm83_bus_pkg::WORD_SIZE-1:0] <= wdata;
		end
	end

endmodule

// File: rtl/sm83_addr_unit.sv
`timescale 1ns/1ps

module sm83_addr_unit (
	input  logic               clk,
	input  logic               reset,
	input  logic               pc_to_adr,
	input  logic               reg_to_adr,
	input  logic               pc_inc_we,
	input  sm83_bus_pkg::adr_t pair_value,
	output sm83_bus_pkg::adr_t mem_adr
);

	sm83_bus_pkg::adr_t pc;
	sm83_bus_pkg::adr_t adr_inc;

	// the incrementer works on the address register, not on PC
	assign adr_inc = mem_adr + sm83_bus_pkg::adr_t'(1);

	always_ff @(posedge clk) begin
		if (reset) begin
			pc      <= sm83_bus_pkg::RESET_PC;
			mem_adr <= sm83_bus_pkg::RESET_PC;
		end else begin
			// new address at the end of T4, held through the access cycle
			if (pc_to_adr)
				mem_adr <= pc;
			else if (reg_to_adr)
				mem_adr <= pair_value;
			// PC steps past a fetched opcode or immediate in T1 of that access
			if (pc_inc_we)
				pc <= adr_inc;
		end
	end

endmodule

// File: rtl/sm83_bus_latch.sv
`timescale 1ns/1ps

module sm83_bus_latch (
	input  logic                  clk,
	input  logic                  reset,
	input  sm83_bus_pkg::word_t   mem_rdata,
	input  sm83_bus_pkg::word_t   reg_rdata,
	input  logic                  data_we,
	input  logic                  data_from_reg,
	input  logic                  ir_we,
	input  logic                  ir_zero,
	input  logic                  wlatch_we,
	output sm83_bus_pkg::word_t   data,
	output sm83_isa_pkg::opcode_u opcode,
	output sm83_bus_pkg::word_t   mem_wdata
);

	sm83_bus_pkg::word_t   data_src;
	sm83_bus_pkg::word_t   wlatch_src;
	sm83_isa_pkg::opcode_u ir_q;
	sm83_isa_pkg::opcode_u ir_next;

	// data_from_reg picks the register byte for both latches
	assign data_src   = data_from_reg ? reg_rdata : mem_rdata;
	// LD (HL),n stores the immediate that sits in the data latch
	assign wlatch_src = data_from_reg ? reg_rdata : data;

	assign ir_next = ir_zero ? sm83_isa_pkg::OP_NOP : data;

	// the IR behaves as a latch open during T4 of M1, so the decoder sees the
	// new opcode in time to plan the next M-cycle
	assign opcode = ir_we ? ir_next : ir_q;

	always_ff @(posedge clk) begin
		if (reset)
			ir_q <= sm83_isa_pkg::OP_NOP;
		else if (ir_we)
			ir_q <= ir_next;
	end

	always_ff @(posedge clk) begin
		if (data_we)
			data <= data_src;
		if (wlatch_we)
			mem_wdata <= wlatch_src;
	end

endmodule

// File: rtl/sm83_core.sv
`timescale 1ns/1ps

module sm83_core (
	input  logic                clk,
	input  logic                reset,
	input  sm83_bus_pkg::word_t mem_rdata,
	output sm83_bus_pkg::adr_t  mem_adr,
	output logic                mem_rd,
	output logic                mem_wr,
	output sm83_bus_pkg::word_t mem_wdata
);

	// sequencer to decoder
	logic m1, m2, m3;
	logic t1, t2, t3, t4;
	logic in_rst;
	logic set_m1;

	// decoder strobes into the data modules
	logic [1:0] reg_sel;
	logic       read_hi, hi_we, lo_we;
	logic       pc_to_adr, reg_to_adr, pc_inc_we;
	logic       data_we, data_from_reg, ir_we, ir_zero, wlatch_we;

	// data paths between the register file, address unit and latches
	sm83_bus_pkg::word_t   reg_rdata;
	sm83_bus_pkg::word_t   data;
	sm83_bus_pkg::adr_t    pair_value;
	sm83_isa_pkg::opcode_u opcode;

	sm83_sequencer u_sequencer (
		.clk, .reset, .set_m1,
		.m1, .m2, .m3, .t1, .t2, .t3, .t4, .in_rst
	);

	sm83_control u_control (
		.opcode, .m1, .m2, .m3, .t1, .t2, .t3, .t4, .in_rst,
		.set_m1, .mem_rd, .mem_wr,
		.reg_sel, .read_hi, .hi_we, .lo_we,
		.pc_to_adr, .reg_to_adr, .pc_inc_we,
		.data_we, .data_from_reg, .ir_we, .ir_zero, .wlatch_we
	);

	// write-back always takes the data latch
	sm83_regfile u_regfile (
		.clk, .reset, .reg_sel, .read_hi, .hi_we, .lo_we,
		.wdata (data),
		.rdata (reg_rdata),
		.pair_value
	);

	sm83_addr_unit u_addr_unit (
		.clk, .reset, .pc_to_adr, .reg_to_adr, .pc_inc_we,
		.pair_value, .mem_adr
	);

	sm83_bus_latch u_bus_latch (
		.clk, .reset, .mem_rdata, .reg_rdata,
		.data_we, .data_from_reg, .ir_we, .ir_zero, .wlatch_we,
		.data, .opcode, .mem_wdata
	);

endmodule

// File: tb/sm83_core_checker.sv
`timescale 1ns/1ps

module sm83_core_checker (
	input logic               clk,
	input logic               reset,
	input logic               mem_rd,
	input logic               mem_wr,
	input logic               t4,
	input sm83_bus_pkg::adr_t mem_adr
);

	// high from a bus strobe until the T4 clock that may load a new address
	logic adr_held;

	always_ff @(posedge clk) begin
		if (reset)
			adr_held <= 1'b0;
		else if (mem_rd || mem_wr)
			adr_held <= 1'b1;
		else if (t4)
			adr_held <= 1'b0;
	end

	// the bus never reads and writes in the same clock
	a_no_overlap: assert property (@(posedge clk) disable iff (reset) !(mem_rd && mem_wr))
		else $error("mem_rd and mem_wr are high in the same clock");

	// each strobe is a single-clock pulse
	a_rd_pulse: assert property (@(posedge clk) disable iff (reset) mem_rd |=> !mem_rd)
		else $error("mem_rd stays high for more than one clock");
	a_wr_pulse: assert property (@(posedge clk) disable iff (reset) mem_wr |=> !mem_wr)
		else $error("mem_wr stays high for more than one clock");

	// the address holds from the strobe through the T4 that ends the access
	a_adr_stable: assert property (@(posedge clk) disable iff (reset)
		(mem_rd || mem_wr || (adr_held && !t4)) |=> $stable(mem_adr))
		else $error("mem_adr moved before the T4 that ends the access");

endmodule

// File: tb/sm83_core_tb.sv
`timescale 1ns/1ps

module sm83_core_tb;

	// five tests of at most about 25 instructions of up to 12 clocks each leave a wide margin
	localparam int MAX_CYCLES = 4000;
	localparam int MEM_TOP = 2 ** sm83_bus_pkg::ADR_WIDTH - 1;

	logic                clk;
	logic                reset;
	sm83_bus_pkg::word_t mem_rdata = '0;
	sm83_bus_pkg::adr_t  mem_adr;
	logic                mem_rd;
	logic                mem_wr;
	sm83_bus_pkg::word_t mem_wdata;

	// memory seen by the DUT and the image that each test loads into it during reset
	sm83_bus_pkg::word_t mem [0:MEM_TOP];
	sm83_bus_pkg::word_t image [0:MEM_TOP];
	// bus log that also keeps the clock count since reset release for each read
	sm83_bus_pkg::adr_t  rd_adr [$];
	int                  rd_at [$];
	sm83_bus_pkg::adr_t  wr_adr [$];
	sm83_bus_pkg::word_t wr_dat [$];
	// expected reads and writes, built up while the program is loaded
	int                  exp_rd [$];
	int                  exp_at [$];
	int                  exp_wa [$];
	int                  exp_wd [$];
	sm83_bus_pkg::adr_t  load_pc;
	int                  next_at;
	int                  since_rst = 0;
	int                  cycles = 0;
	int                  checks;
	int                  errors;
	integer              seed;
	string               test_name;

	sm83_core u_dut (
		.clk, .reset, .mem_rdata, .mem_adr, .mem_rd, .mem_wr, .mem_wdata
	);

	bind sm83_core sm83_core_checker u_checker (
		.clk, .reset, .mem_rd, .mem_wr, .t4, .mem_adr
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// count clocks since reset release and stop the run at the limit
	always @(posedge clk) begin
		since_rst <= reset ? 0 : since_rst + 1;
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d clocks", MAX_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// the memory model samples mid-clock where the strobes and address have settled
	always @(negedge clk) begin
		if (reset) begin
			mem = image;
			rd_adr.delete();
			rd_at.delete();
			wr_adr.delete();
			wr_dat.delete();
		end
		if (mem_rd) begin
			rd_adr.push_back(mem_adr);
			rd_at.push_back(since_rst);
		end
		if (mem_wr) begin
			mem[mem_adr] = mem_wdata;
			wr_adr.push_back(mem_adr);
			wr_dat.push_back(mem_wdata);
		end
		// read data is valid long before the T3 edge samples it
		mem_rdata <= mem[mem_adr];
	end

	function automatic sm83_bus_pkg::word_t rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic check_value(string what, int got, int want);
		checks++;
		if (got != want) begin
			errors++;
			$display("Fail %0t: %s, %s is %0h, expected %0h", $time, test_name, what, got, want);
		end
	endtask

	task automatic hold_reset(string name);
		test_name = name;
		@(negedge clk);
		reset = 1'b1;
		foreach (image[i])
			image[i] = '0;
		exp_rd.delete();
		exp_at.delete();
		exp_wa.delete();
		exp_wd.delete();
		load_pc = sm83_bus_pkg::RESET_PC;
		// the forced nop takes four clocks, so the first fetch lands in the fifth
		next_at = 4;
	endtask

	task automatic emit(sm83_bus_pkg::word_t b);
		image[load_pc] = b;
		load_pc++;
	endtask

	// k M-cycles put 4k clocks between this fetch and the next one
	// a second read sits in M2 four clocks after the fetch
	task automatic put_op(sm83_bus_pkg::word_t op, int mcycles, int extra);
		exp_rd.push_back(int'(load_pc));
		exp_at.push_back(next_at);
		if (extra >= 0) begin
			exp_rd.push_back(extra);
			exp_at.push_back(next_at + 4);
		end
		next_at += 4 * mcycles;
		emit(op);
	endtask

	task automatic put_op_n(sm83_bus_pkg::word_t op, sm83_bus_pkg::word_t n, int mcycles);
		put_op(op, mcycles, int'(load_pc) + 1);
		emit(n);
	endtask

	task automatic expect_write(int adr, int dat);
		exp_wa.push_back(adr);
		exp_wd.push_back(dat);
	endtask

	// trailing nops keep the run going past the last store
	task automatic run_and_check();
		repeat (3)
			put_op(sm83_isa_pkg::OP_NOP, 1, -1);
		repeat (4) @(negedge clk);
		reset = 1'b0;
		while (wr_adr.size() < exp_wa.size() || rd_adr.size() < exp_rd.size())
			@(negedge clk);
		foreach (exp_rd[i]) begin
			check_value($sformatf("read %0d address", i), int'(rd_adr[i]), exp_rd[i]);
			check_value($sformatf("read %0d clock", i), rd_at[i], exp_at[i]);
		end
		check_value("write count", wr_adr.size(), exp_wa.size());
		foreach (exp_wa[i]) begin
			if (i < wr_adr.size()) begin
				check_value($sformatf("write %0d address", i), int'(wr_adr[i]), exp_wa[i]);
				check_value($sformatf("write %0d data", i), int'(wr_dat[i]), exp_wd[i]);
			end
		end
	endtask

	task automatic fetch_after_reset();
		// a nop and then opcodes outside the kept set that all take one M-cycle
		sm83_bus_pkg::word_t ops [8] = '{8'h00, 8'h76, 8'hD3, 8'h22, 8'h01, 8'hCB, 8'hE0, 8'h10};
		hold_reset("reset fetch");
		foreach (ops[i])
			put_op(ops[i], 1, -1);
		run_and_check();
	endtask

	task automatic store_b_at_hl();
		sm83_bus_pkg::word_t h;
		sm83_bus_pkg::word_t l;
		sm83_bus_pkg::word_t b;
		hold_reset("LD (HL),B");
		// H keeps bit 7 so the store stays clear of the program
		h = rand_byte() | 8'h80;
		l = rand_byte();
		b = rand_byte();
		put_op_n(8'h26, h, 2);
		put_op_n(8'h2E, l, 2);
		put_op_n(8'h06, b, 2);
		put_op(8'h70, 2, -1);
		expect_write(int'({h, l}), int'(b));
		run_and_check();
	endtask

	task automatic move_reg_chain();
		sm83_bus_pkg::word_t n;
		sm83_bus_pkg::word_t c_lo;
		sm83_bus_pkg::word_t e_lo;
		sm83_bus_pkg::word_t m;
		hold_reset("LD r,r' chain");
		n = rand_byte() | 8'h80;
		c_lo = rand_byte();
		e_lo = rand_byte();
		m = rand_byte();
		// B to C to D to E to A crosses high and low halves of each pair
		put_op_n(8'h06, n, 2);
		put_op(8'h48, 1, -1);
		put_op(8'h51, 1, -1);
		put_op(8'h5A, 1, -1);
		put_op(8'h7B, 1, -1);
		put_op_n(8'h0E, c_lo, 2);
		put_op_n(8'h1E, e_lo, 2);
		put_op(8'h02, 2, -1);
		put_op_n(8'h3E, m, 2);
		put_op(8'h12, 2, -1);
		expect_write(int'({n, c_lo}), int'(n));
		expect_write(int'({n, e_lo}), int'(m));
		run_and_check();
	endtask

	task automatic load_from_memory();
		sm83_bus_pkg::word_t dh;
		sm83_bus_pkg::word_t dl;
		sm83_bus_pkg::word_t hh;
		sm83_bus_pkg::word_t hl;
		sm83_bus_pkg::word_t x;
		sm83_bus_pkg::word_t y;
		hold_reset("LD A,(DE) and LD B,(HL)");
		dh = rand_byte() | 8'h80;
		dl = rand_byte();
		// flipping bit 6 keeps HL apart from DE
		hh = dh ^ 8'h40;
		hl = rand_byte();
		x = rand_byte();
		y = rand_byte();
		image[{dh, dl}] = x;
		image[{hh, hl}] = y;
		put_op_n(8'h16, dh, 2);
		put_op_n(8'h1E, dl, 2);
		put_op_n(8'h26, hh, 2);
		put_op_n(8'h2E, hl, 2);
		put_op(8'h1A, 2, int'({dh, dl}));
		put_op(8'h46, 2, int'({hh, hl}));
		put_op(8'h77, 2, -1);
		put_op(8'h70, 2, -1);
		expect_write(int'({hh, hl}), int'(x));
		expect_write(int'({hh, hl}), int'(y));
		run_and_check();
	endtask

	task automatic store_imm_at_hl();
		sm83_bus_pkg::word_t hh;
		sm83_bus_pkg::word_t hl;
		sm83_bus_pkg::word_t n;
		hold_reset("LD (HL),n");
		hh = rand_byte() | 8'h80;
		hl = rand_byte();
		n = rand_byte();
		put_op_n(8'h26, hh, 2);
		put_op_n(8'h2E, hl, 2);
		// three M-cycles pass before the next fetch two bytes on
		put_op_n(sm83_isa_pkg::OP_LD_HL_N, n, 3);
		expect_write(int'({hh, hl}), int'(n));
		run_and_check();
	endtask

	initial begin
		reset = 1'b1;
		seed = 32'hadb22555;
		checks = 0;
		errors = 0;
		fetch_after_reset();
		store_b_at_hl();
		move_reg_chain();
		load_from_memory();
		store_imm_at_hl();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: compile.f
rtl/sm83_bus_pkg.sv
rtl/sm83_isa_pkg.sv
rtl/sm83_sequencer.sv
rtl/sm83_control.sv
rtl/sm83_regfile.sv
rtl/sm83_addr_unit.sv
rtl/sm83_bus_latch.sv
rtl/sm83_core.sv
tb/sm83_core_checker.sv
tb/sm83_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and report failure from the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --top-module sm83_core_tb \
	-Mdir obj_dir -o sm83_core_sim -f compile.f

./obj_dir/sm83_core_sim | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
	echo "run.sh: simulation reported a failure"
	exit 1
fi
echo "run.sh: simulation finished without failures"
